/* rtl/rob_cfg_regs.sv */
/*
  commit policy registers
  loaded whole on cfg_wr, new values seen from the next cycle
  reset value is dual commit with one branch per cycle
  flush leaves the settings alone
*/
module rob_cfg_regs (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cfg_wr,
  input  rob_pkg::rob_cfg_t cfg_wdata,
  output rob_pkg::rob_cfg_t cfg
);

  import rob_pkg::*;

  rob_cfg_t cfg_q;

  // ==============================
  // policy storage
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q.commit_limit     <= 1'b1;
      cfg_q.single_branch_en <= 1'b1;
    end else if (cfg_wr) begin
      cfg_q <= cfg_wdata;
    end
  end

  // straight from the flops, no bypass of a write in flight
  assign cfg = cfg_q;

endmodule

/* rtl/rob_commit_sel.sv */
/*
  in-order retirement from the two oldest entries
  lane 1 is held back behind an exception or a redirect so recovery
  starts from a drained pipeline
  purely combinational from registered state
*/
`include "rob_config.svh"

module rob_commit_sel (
  input  logic [rob_pkg::rob_idx_w:0]             count,
  input  rob_pkg::rob_entry_t [`COMMIT_WIDTH-1:0] head_entries,
  input  rob_pkg::rob_cfg_t                       cfg,
  output rob_pkg::rob_cmt_t                       cmt,
  output logic [1:0]                              commit_cnt
);

  import rob_pkg::*;

  logic [`COMMIT_WIDTH-1:0] valid_mask;
  logic                     redirect_mask;
  logic                     exc_mask;
  logic                     br_mask;
  logic                     limit_mask;
  logic [`COMMIT_WIDTH-1:0] commit_valid;

  // ==============================
  // lane masks
  // ==============================
  assign valid_mask[0] = count >= 1;
  assign valid_mask[1] = count >= 2;

  // lane 1 only, the head itself is never masked
  assign redirect_mask = ~head_entries[1].br_redirect;
  assign exc_mask      = ~head_entries[1].excp.valid;
  // branch predictor has a single update port
  assign br_mask       = ~cfg.single_branch_en | (head_entries[0].instr_type != it_branch);
  assign limit_mask    = cfg.commit_limit;

  assign commit_valid[0] = valid_mask[0] & head_entries[0].complete;
  assign commit_valid[1] = commit_valid[0] & valid_mask[1] & head_entries[1].complete &
                           redirect_mask & exc_mask & br_mask & limit_mask;

  // lane 1 implies lane 0, so the count is 0, 1 or 2
  assign commit_cnt = {1'b0, commit_valid[0]} + {1'b0, commit_valid[1]};

  assign cmt.valid = commit_valid;
  assign cmt.entry = head_entries;

endmodule

/* rtl/rob_config.svh */
/*
  reorder buffer build settings
  ROB_DEPTH must be a power of two, 4 or more
  DECODE_WIDTH and COMMIT_WIDTH are fixed at 2 by the commit logic
*/
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// ==============================
// buffer geometry
// ==============================
`define ROB_DEPTH     8
`define DECODE_WIDTH  2
`define COMMIT_WIDTH  2

// ==============================
// datapath widths
// ==============================
`define PC_W          32
`define AREG_W        5
`define PREG_W        6

`endif

/* rtl/rob_entry_array.sv */
/*
  reorder buffer entry storage
  one ALU port, always ready, and one memory port
  non-load memory write-backs wait until their entry is the oldest
  payload is not reset, completion flags are
  a write-back to an unallocated index is not checked
*/
`include "rob_config.svh"

module rob_entry_array (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    alloc_fire,
  input  rob_pkg::rob_ptr_t                       tail_ptr,
  input  rob_pkg::rob_alloc_req_t                 alloc_req,
  input  rob_pkg::rob_idx_t                       head_idx,
  input  rob_pkg::rob_wb_t                        alu_wb,
  input  rob_pkg::rob_wb_t                        mem_wb,
  output logic                                    mem_wb_ready,
  output rob_pkg::rob_entry_t [`COMMIT_WIDTH-1:0] head_entries
);

  import rob_pkg::*;

  rob_entry_t [`ROB_DEPTH-1:0] ent_q;
  rob_entry_t [`ROB_DEPTH-1:0] ent_n;
  logic [`ROB_DEPTH-1:0] cmpl_q;
  logic [`ROB_DEPTH-1:0] cmpl_n;
  rob_idx_t [`DECODE_WIDTH-1:0] lane_idx;
  rob_idx_t [`COMMIT_WIDTH-1:0] rd_idx;

  // result fields from a write-back, ALU results never raise exceptions
  function automatic rob_entry_t apply_wb(rob_entry_t e, rob_wb_t wb, logic keep_excp);
    rob_entry_t r;
    r             = e;
    r.excp        = keep_excp ? wb.excp : '0;
    r.br_redirect = wb.br_redirect;
    r.br_target   = wb.br_target;
    return r;
  endfunction

  // stores and other side-effecting ops only at the head
  assign mem_wb_ready = (mem_wb.instr_type == it_load) | (mem_wb.rob_idx == head_idx);

  always_comb begin
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      lane_idx[i] = tail_ptr.idx + rob_idx_t'(i);
    end
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      rd_idx[i] = head_idx + rob_idx_t'(i);
    end
  end

  // ==============================
  // allocation and write-back
  // ==============================
  always_comb begin
    ent_n  = ent_q;
    cmpl_n = cmpl_q;

    if (alloc_fire) begin
      for (int i = 0; i < `DECODE_WIDTH; i++) begin
        if (alloc_req.valid[i]) begin
          ent_n[lane_idx[i]]            = '0;
          ent_n[lane_idx[i]].pc         = alloc_req.pc[i];
          ent_n[lane_idx[i]].instr_type = alloc_req.instr_type[i];
          ent_n[lane_idx[i]].arch_reg   = alloc_req.arch_reg[i];
          ent_n[lane_idx[i]].phy_reg    = alloc_req.phy_reg[i];
          ent_n[lane_idx[i]].excp       = alloc_req.excp[i];
          // faulting instructions never execute, so they are done already
          cmpl_n[lane_idx[i]]           = alloc_req.excp[i].valid;
        end
      end
    end

    if (alu_wb.valid) begin
      ent_n[alu_wb.rob_idx]  = apply_wb(ent_n[alu_wb.rob_idx], alu_wb, 1'b0);
      cmpl_n[alu_wb.rob_idx] = 1'b1;
    end

    // memory port applied last
    if (mem_wb.valid && mem_wb_ready) begin
      ent_n[mem_wb.rob_idx]  = apply_wb(ent_n[mem_wb.rob_idx], mem_wb, 1'b1);
      cmpl_n[mem_wb.rob_idx] = 1'b1;
    end
  end

  // ==============================
  // storage
  // ==============================
  always_ff @(posedge clk) begin
    ent_q <= ent_n;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmpl_q <= '0;
    end else begin
      cmpl_q <= cmpl_n;
    end
  end

  // oldest entries, complete flag merged in from the flag vector
  always_comb begin
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      head_entries[i]          = ent_q[rd_idx[i]];
      head_entries[i].complete = cmpl_q[rd_idx[i]];
    end
  end

endmodule

/* rtl/rob_pkg.sv */
/*
  shared types for the reorder buffer
  per-lane fields are packed arrays indexed by lane number
  rob_entry_t.complete is only meaningful on the commit bundle
*/
`include "rob_config.svh"

package rob_pkg;

  localparam int rob_idx_w = $clog2(`ROB_DEPTH);

  typedef logic [rob_idx_w-1:0] rob_idx_t;

  typedef struct packed {
    logic     wrap;
    rob_idx_t idx;
  } rob_ptr_t;

  typedef enum logic [1:0] {
    it_alu    = 2'd0,
    it_branch = 2'd1,
    it_load   = 2'd2,
    it_store  = 2'd3
  } instr_type_e;

  typedef struct packed {
    logic       valid;
    logic [5:0] code;
  } excp_t;

  // ==============================
  // stored entry and interfaces
  // ==============================
  typedef struct packed {
    logic               complete;
    logic [`PC_W-1:0]   pc;
    instr_type_e        instr_type;
    logic [`AREG_W-1:0] arch_reg;
    logic [`PREG_W-1:0] phy_reg;
    excp_t              excp;
    logic               br_redirect;
    logic [`PC_W-1:0]   br_target;
  } rob_entry_t;

  typedef struct packed {
    logic [`DECODE_WIDTH-1:0]              valid;
    logic                                  req;
    logic [`DECODE_WIDTH-1:0][`PC_W-1:0]   pc;
    instr_type_e [`DECODE_WIDTH-1:0]       instr_type;
    logic [`DECODE_WIDTH-1:0][`AREG_W-1:0] arch_reg;
    logic [`DECODE_WIDTH-1:0][`PREG_W-1:0] phy_reg;
    excp_t [`DECODE_WIDTH-1:0]             excp;
  } rob_alloc_req_t;

  typedef struct packed {
    logic                           ready;
    rob_idx_t [`DECODE_WIDTH-1:0]   rob_idx;
    logic [`DECODE_WIDTH-1:0]       wrap;
  } rob_alloc_rsp_t;

  // instr_type lets the memory port tell loads from the rest
  typedef struct packed {
    logic             valid;
    rob_idx_t         rob_idx;
    excp_t            excp;
    logic             br_redirect;
    logic [`PC_W-1:0] br_target;
    instr_type_e      instr_type;
  } rob_wb_t;

  typedef struct packed {
    logic [`COMMIT_WIDTH-1:0]       valid;
    rob_entry_t [`COMMIT_WIDTH-1:0] entry;
  } rob_cmt_t;

  typedef struct packed {
    logic commit_limit;
    logic single_branch_en;
  } rob_cfg_t;

endpackage

/* rtl/rob_ptr_ctrl.sv */
/*
  head, tail and occupancy tracking
  pointers carry a wrap bit above the index
  ready depends on count only, a request seen while low changes nothing
  flush wins over allocation and commit in the same cycle
*/
`include "rob_config.svh"

module rob_ptr_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  logic [`DECODE_WIDTH-1:0]  alloc_req_valid,
  input  logic                      alloc_req,
  input  logic [1:0]                commit_cnt,
  output rob_pkg::rob_alloc_rsp_t   alloc_rsp,
  output logic                      alloc_fire,
  output rob_pkg::rob_ptr_t         tail_ptr,
  output rob_pkg::rob_idx_t         head_idx,
  output logic [rob_pkg::rob_idx_w:0] count
);

  import rob_pkg::*;

  localparam logic [rob_idx_w:0] alloc_max = (rob_idx_w + 1)'(`ROB_DEPTH - `DECODE_WIDTH);

  logic [rob_idx_w:0] head_q;
  logic [rob_idx_w:0] tail_q;
  logic [rob_idx_w:0] cnt_q;
  logic [rob_idx_w:0] alloc_cnt;
  logic [rob_idx_w:0] cmt_ext;
  logic [`DECODE_WIDTH-1:0][rob_idx_w:0] lane_ptr;

  assign alloc_rsp.ready = cnt_q <= alloc_max;
  assign alloc_fire      = alloc_req & alloc_rsp.ready & ~flush;
  assign cmt_ext         = {{(rob_idx_w - 1){1'b0}}, commit_cnt};

  // lanes fill from 0 upward, so the count is the tail step
  always_comb begin
    alloc_cnt = '0;
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      alloc_cnt = alloc_cnt + {{rob_idx_w{1'b0}}, alloc_req_valid[i]};
    end
  end

  // indices handed back to the front end
  always_comb begin
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      lane_ptr[i]          = tail_q + (rob_idx_w + 1)'(i);
      alloc_rsp.rob_idx[i] = lane_ptr[i][rob_idx_w-1:0];
      alloc_rsp.wrap[i]    = lane_ptr[i][rob_idx_w];
    end
  end

  // ==============================
  // pointer and count registers
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= '0;
    end else if (flush) begin
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= '0;
    end else begin
      head_q <= head_q + cmt_ext;
      if (alloc_fire) begin
        tail_q <= tail_q + alloc_cnt;
      end
      cnt_q <= cnt_q + (alloc_fire ? alloc_cnt : '0) - cmt_ext;
    end
  end

  assign tail_ptr = '{wrap: tail_q[rob_idx_w], idx: tail_q[rob_idx_w-1:0]};
  assign head_idx = head_q[rob_idx_w-1:0];
  assign count    = cnt_q;

endmodule

/* rtl/rob_top.sv */
/*
  reorder buffer top level
  alloc fires when req and ready are both high, lanes valid from 0 up
  the ALU write-back port is always ready
  flush and configuration writes are single-cycle strobes
*/
`include "rob_config.svh"

module rob_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  rob_pkg::rob_alloc_req_t alloc_req,
  output rob_pkg::rob_alloc_rsp_t alloc_rsp,
  input  rob_pkg::rob_wb_t        alu_wb,
  input  rob_pkg::rob_wb_t        mem_wb,
  output logic                    mem_wb_ready,
  input  logic                    cfg_wr,
  input  rob_pkg::rob_cfg_t       cfg_wdata,
  output rob_pkg::rob_cmt_t       cmt
);

  import rob_pkg::*;

  logic                            alloc_fire;
  rob_ptr_t                        tail_ptr;
  rob_idx_t                        head_idx;
  logic [rob_idx_w:0]              count;
  logic [1:0]                      commit_cnt;
  rob_entry_t [`COMMIT_WIDTH-1:0]  head_entries;
  rob_cfg_t                        cfg;

  rob_cfg_regs i_rob_cfg_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  rob_ptr_ctrl i_rob_ptr_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush           (flush),
    .alloc_req_valid (alloc_req.valid),
    .alloc_req       (alloc_req.req),
    .commit_cnt      (commit_cnt),
    .alloc_rsp       (alloc_rsp),
    .alloc_fire      (alloc_fire),
    .tail_ptr        (tail_ptr),
    .head_idx        (head_idx),
    .count           (count)
  );

  rob_entry_array i_rob_entry_array (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_fire   (alloc_fire),
    .tail_ptr     (tail_ptr),
    .alloc_req    (alloc_req),
    .head_idx     (head_idx),
    .alu_wb       (alu_wb),
    .mem_wb       (mem_wb),
    .mem_wb_ready (mem_wb_ready),
    .head_entries (head_entries)
  );

  rob_commit_sel i_rob_commit_sel (
    .count        (count),
    .head_entries (head_entries),
    .cfg          (cfg),
    .cmt          (cmt),
    .commit_cnt   (commit_cnt)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the reorder buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module rob_tb \
  -f sources.f \
  -o rob_sim

out="$(./obj_dir/rob_sim)"
echo "$out"

if grep -qx "Simulation finished: PASS" <<< "$out"; then
  exit 0
else
  exit 1
fi

/* sources.f */
+incdir+rtl
+incdir+testbench
rtl/rob_pkg.sv
rtl/rob_cfg_regs.sv
rtl/rob_ptr_ctrl.sv
rtl/rob_entry_array.sv
rtl/rob_commit_sel.sv
rtl/rob_top.sv
testbench/rob_tb.sv

/* testbench/rob_tb_table.svh */
/*
  per-cycle stimulus rows for the reorder buffer testbench
  one row is applied each clock, outputs sampled just before the next edge
  lane pcs and register fields are not in the rows, they come from xorshift
  instruction type codes are 0 alu, 1 branch, 2 load, 3 store
*/
`ifndef ROB_TB_TABLE_SVH
`define ROB_TB_TABLE_SVH

typedef struct {
  bit req;
  int n;
  int t0;
  int t1;
  bit x0;
  bit x1;
  bit av;
  int ai;
  bit ar;
  bit mv;
  int mi;
  int mt;
  bit fl;
  bit cw;
  bit lim;
  bit sbr;
  bit rdy;
  bit mrdy;
  bit v0;
  bit v1;
} row_t;

localparam int n_rows = 45;

row_t tbl [n_rows];

function automatic row_t mk(input int req, n, t0, t1, x0, x1, av, ai, ar,
                            input int mv, mi, mt, fl, cw, lim, sbr,
                            input int rdy, mrdy, v0, v1);
  row_t r;
  r.req  = req[0];
  r.n    = n;
  r.t0   = t0;
  r.t1   = t1;
  r.x0   = x0[0];
  r.x1   = x1[0];
  r.av   = av[0];
  r.ai   = ai;
  r.ar   = ar[0];
  r.mv   = mv[0];
  r.mi   = mi;
  r.mt   = mt;
  r.fl   = fl[0];
  r.cw   = cw[0];
  r.lim  = lim[0];
  r.sbr  = sbr[0];
  r.rdy  = rdy[0];
  r.mrdy = mrdy[0];
  r.v0   = v0[0];
  r.v1   = v1[0];
  return r;
endfunction

function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

task automatic load_table();
  // req n t0 t1 x0 x1 | alu v idx redir | mem v idx type | flush cfg lim sbr | rdy mrdy v0 v1
  // ==============================
  // in-order retirement after reverse write-back
  // ==============================
  tbl[0]  = mk(1, 2, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[1]  = mk(1, 2, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[2]  = mk(0, 0, 0, 0, 0, 0,  1, 3, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[3]  = mk(0, 0, 0, 0, 0, 0,  1, 2, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[4]  = mk(0, 0, 0, 0, 0, 0,  1, 1, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[5]  = mk(0, 0, 0, 0, 0, 0,  1, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[6]  = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 1, 1);
  tbl[7]  = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 1, 1);
  // branch rule and commit width limit
  tbl[8]  = mk(1, 2, 1, 2, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[9]  = mk(0, 0, 0, 0, 0, 0,  1, 4, 0,  1, 5, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[10] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 1, 0);
  tbl[11] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 1, 1, 0,  1, 1, 1, 0);
  tbl[12] = mk(1, 2, 1, 2, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[13] = mk(0, 0, 0, 0, 0, 0,  1, 6, 0,  1, 7, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[14] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 1, 0, 0,  1, 1, 1, 1);
  tbl[15] = mk(1, 2, 0, 2, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[16] = mk(0, 0, 0, 0, 0, 0,  1, 0, 0,  1, 1, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[17] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 1, 0);
  tbl[18] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 1, 1, 1,  1, 1, 1, 0);
  // redirect and exception in lane 1
  tbl[19] = mk(1, 2, 2, 1, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[20] = mk(0, 0, 0, 0, 0, 0,  1, 3, 1,  1, 2, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[21] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 1, 0);
  tbl[22] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 1, 0);
  tbl[23] = mk(1, 2, 0, 0, 0, 1,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[24] = mk(0, 0, 0, 0, 0, 0,  1, 4, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[25] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 1, 0);
  tbl[26] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 1, 0);
  // fill up, back-pressure, then space frees
  tbl[27] = mk(1, 2, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[28] = mk(1, 2, 0, 3, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[29] = mk(1, 2, 2, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[30] = mk(1, 2, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[31] = mk(1, 2, 3, 2, 0, 0,  1, 6, 0,  0, 0, 2,  0, 0, 0, 0,  0, 1, 0, 0);
  tbl[32] = mk(1, 2, 3, 2, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  0, 1, 1, 0);
  tbl[33] = mk(1, 2, 3, 2, 0, 0,  1, 7, 0,  0, 0, 2,  0, 0, 0, 0,  0, 1, 0, 0);
  tbl[34] = mk(1, 2, 3, 2, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  0, 1, 1, 0);
  tbl[35] = mk(1, 2, 3, 2, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  // store waits for the head, load does not
  tbl[36] = mk(0, 0, 0, 0, 0, 0,  1, 0, 0,  1, 1, 3,  0, 0, 0, 0,  0, 0, 0, 0);
  tbl[37] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  1, 2, 2,  0, 0, 0, 0,  0, 1, 1, 0);
  tbl[38] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  1, 1, 3,  0, 0, 0, 0,  0, 1, 0, 0);
  tbl[39] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  0, 1, 1, 1);
  // flush drops the allocation offered with it
  tbl[40] = mk(1, 2, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  1, 0, 0, 0,  1, 1, 0, 0);
  tbl[41] = mk(1, 2, 0, 2, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[42] = mk(0, 0, 0, 0, 0, 0,  1, 0, 0,  1, 1, 2,  0, 0, 0, 0,  1, 1, 0, 0);
  tbl[43] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 1, 1);
  tbl[44] = mk(0, 0, 0, 0, 0, 0,  0, 0, 0,  0, 0, 2,  0, 0, 0, 0,  1, 1, 0, 0);
endtask

`endif

/* testbench/rob_tb.sv */
/*
  table-driven testbench for the reorder buffer
  inputs change 1 unit after the rising edge, outputs sampled 1 unit before
  committed entries are checked against a model of the buffer contents
  a refused allocation is offered again with the same lane data
*/
module rob_tb;

  import rob_pkg::*;

  `include "rob_tb_table.svh"

  logic           clk;
  logic           rst_n;
  logic           flush;
  logic           cfg_wr;
  rob_cfg_t       cfg_wdata;
  rob_alloc_req_t alloc_req;
  rob_alloc_rsp_t alloc_rsp;
  rob_wb_t        alu_wb;
  rob_wb_t        mem_wb;
  logic           mem_wb_ready;
  rob_cmt_t       cmt;

  int          errors;
  logic [31:0] rnd;
  rob_entry_t  model [8];
  logic [3:0]  head_m;
  logic [3:0]  tail_m;
  int          cnt_m;
  logic        held;
  logic [1:0][31:0] lane_pc;
  logic [1:0][4:0]  lane_areg;
  logic [1:0][5:0]  lane_preg;
  logic [1:0][5:0]  lane_code;
  logic        ok;

  rob_top i_rob_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .alloc_req    (alloc_req),
    .alloc_rsp    (alloc_rsp),
    .alu_wb       (alu_wb),
    .mem_wb       (mem_wb),
    .mem_wb_ready (mem_wb_ready),
    .cfg_wr       (cfg_wr),
    .cfg_wdata    (cfg_wdata),
    .cmt          (cmt)
  );

  always #2 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  // every field of one commit lane against the model entry
  task automatic check_commit(input int lane, input rob_entry_t exp);
    rob_entry_t got;
    string      pfx;
    got = cmt.entry[lane];
    pfx = $sformatf("cmt.entry[%0d]", lane);
    check({pfx, ".complete"}, got.complete, exp.complete);
    check({pfx, ".pc"}, got.pc, exp.pc);
    check({pfx, ".instr_type"}, got.instr_type, exp.instr_type);
    check({pfx, ".arch_reg"}, got.arch_reg, exp.arch_reg);
    check({pfx, ".phy_reg"}, got.phy_reg, exp.phy_reg);
    check({pfx, ".excp"}, got.excp, exp.excp);
    check({pfx, ".br_redirect"}, got.br_redirect, exp.br_redirect);
    check({pfx, ".br_target"}, got.br_target, exp.br_target);
  endtask

  // ==============================
  // stimulus
  // ==============================
  task automatic drive_row(input row_t r);
    if (r.req && !held) begin
      for (int l = 0; l < 2; l++) begin
        rnd          = xorshift(rnd);
        lane_pc[l]   = {rnd[31:2], 2'b00};
        rnd          = xorshift(rnd);
        lane_areg[l] = rnd[4:0];
        lane_preg[l] = rnd[10:5];
        lane_code[l] = rnd[16:11];
      end
    end
    alloc_req.req   = r.req;
    alloc_req.valid = (r.n == 2) ? 2'b11 : ((r.n == 1) ? 2'b01 : 2'b00);
    for (int l = 0; l < 2; l++) begin
      alloc_req.pc[l]         = lane_pc[l];
      alloc_req.arch_reg[l]   = lane_areg[l];
      alloc_req.phy_reg[l]    = lane_preg[l];
      alloc_req.excp[l].code  = lane_code[l];
    end
    alloc_req.instr_type[0] = instr_type_e'(r.t0[1:0]);
    alloc_req.instr_type[1] = instr_type_e'(r.t1[1:0]);
    alloc_req.excp[0].valid = r.x0;
    alloc_req.excp[1].valid = r.x1;
    rnd                = xorshift(rnd);
    alu_wb             = '0;
    alu_wb.valid       = r.av;
    alu_wb.rob_idx     = rob_idx_t'(r.ai);
    alu_wb.br_redirect = r.ar;
    alu_wb.br_target   = rnd;
    mem_wb             = '0;
    mem_wb.valid       = r.mv;
    mem_wb.rob_idx     = rob_idx_t'(r.mi);
    mem_wb.instr_type  = instr_type_e'(r.mt[1:0]);
    flush              = r.fl;
    cfg_wr             = r.cw;
    cfg_wdata.commit_limit     = r.lim;
    cfg_wdata.single_branch_en = r.sbr;
  endtask

  // compare outputs, then step the buffer model
  task automatic check_row(input row_t r);
    logic     fire;
    int       n_cmt;
    rob_idx_t idx;
    bit       xl;
    int       tl;
    check("alloc_rsp.ready", alloc_rsp.ready, r.rdy);
    check("mem_wb_ready", mem_wb_ready, r.mrdy);
    check("cmt.valid[0]", cmt.valid[0], r.v0);
    check("cmt.valid[1]", cmt.valid[1], r.v1);
    if (r.req) begin
      check("alloc_rsp.rob_idx[0]", alloc_rsp.rob_idx[0], tail_m[2:0]);
      check("alloc_rsp.wrap[0]", alloc_rsp.wrap[0], tail_m[3]);
      check("alloc_rsp.rob_idx[1]", alloc_rsp.rob_idx[1], 3'(tail_m + 4'd1));
      check("alloc_rsp.wrap[1]", alloc_rsp.wrap[1], 1'((tail_m + 4'd1) >> 3));
    end
    n_cmt = int'(r.v0) + int'(r.v1);
    if (cnt_m < n_cmt) begin
      errors++;
      $display("model holds fewer instructions than the row expects to commit");
    end else begin
      if (r.v0) begin
        check_commit(0, model[head_m[2:0]]);
      end
      if (r.v1) begin
        check_commit(1, model[3'(head_m + 4'd1)]);
      end
      head_m = head_m + 4'(n_cmt);
      cnt_m  = cnt_m - n_cmt;
    end
    fire = r.req & r.rdy & ~r.fl;
    if (fire) begin
      for (int l = 0; l < r.n; l++) begin
        xl  = (l == 0) ? r.x0 : r.x1;
        tl  = (l == 0) ? r.t0 : r.t1;
        idx = 3'(tail_m + 4'(l));
        model[idx]            = '0;
        model[idx].complete   = xl;
        model[idx].pc         = lane_pc[l];
        model[idx].instr_type = instr_type_e'(tl[1:0]);
        model[idx].arch_reg   = lane_areg[l];
        model[idx].phy_reg    = lane_preg[l];
        model[idx].excp.valid = xl;
        model[idx].excp.code  = lane_code[l];
      end
      tail_m = tail_m + 4'(r.n);
      cnt_m  = cnt_m + r.n;
    end
    // ALU results carry no exception, memory results here carry none either
    if (!r.fl && r.av) begin
      idx = rob_idx_t'(r.ai);
      model[idx].complete    = 1'b1;
      model[idx].excp        = '0;
      model[idx].br_redirect = r.ar;
      model[idx].br_target   = alu_wb.br_target;
    end
    if (!r.fl && r.mv && r.mrdy) begin
      idx = rob_idx_t'(r.mi);
      model[idx].complete    = 1'b1;
      model[idx].excp        = '0;
      model[idx].br_redirect = 1'b0;
      model[idx].br_target   = '0;
    end
    held = r.req & ~fire;
    if (r.fl) begin
      head_m = '0;
      tail_m = '0;
      cnt_m  = 0;
    end
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    flush     = 1'b0;
    cfg_wr    = 1'b0;
    cfg_wdata = '0;
    alloc_req = '0;
    alu_wb    = '0;
    mem_wb    = '0;
    errors    = 0;
    rnd       = 32'h1ce4;
    head_m    = '0;
    tail_m    = '0;
    cnt_m     = 0;
    held      = 1'b0;
    lane_pc   = '0;
    lane_areg = '0;
    lane_preg = '0;
    lane_code = '0;
    ok        = 1'b0;
    load_table();

    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;

    for (int i = 0; i < 20 && !ok; i++) begin
      @(posedge clk);
      #3;
      ok = (alloc_rsp.ready === 1'b1) && (cmt.valid === 2'b00);
    end
    if (!ok) begin
      errors++;
      $display("timed out waiting for the buffer to come out of reset");
    end else begin
      for (int i = 0; i < n_rows; i++) begin
        @(posedge clk);
        #1;
        drive_row(tbl[i]);
        #2;
        check_row(tbl[i]);
      end
      ok = 1'b0;
      for (int i = 0; i < 16 && !ok; i++) begin
        @(posedge clk);
        #3;
        ok = (cmt.valid === 2'b00);
      end
      if (!ok) begin
        errors++;
        $display("timed out waiting for commits to drain at the end");
      end
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
